/* rtl/trig_break_hold.sv */
/*
 * break request holding register
 * captures a hit with its pc, holds it until the core acknowledges
 */
`timescale 1ns/1ps

module trig_break_hold (
	input  logic                  clk,
	input  logic                  rst_n,
	input  trig_pkg::core_state_t core,
	input  trig_pkg::break_t      brk,       // combinational match result
	input  logic                  break_ack,
	output logic                  break_req,
	output logic                  break_to_dmode,
	output trig_pkg::xlen_t       break_pc
);

	logic capture;  // qualified hit with nothing pending

	// new hits are dropped while a request waits for its ack
	assign capture = core.pc_valid && brk.any && !break_req;

	// --------------------------------------------------------------------------
	// pending request

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			break_req      <= 1'b0;
			break_to_dmode <= 1'b0;
		end else if (capture) begin
			break_req      <= 1'b1;
			break_to_dmode <= brk.d_mode;
		end else if (break_ack) begin
			break_req      <= 1'b0;  // drops one cycle after the ack
			break_to_dmode <= 1'b0;
		end
	end

	// --------------------------------------------------------------------------
	// break pc, also read back as tbreakpc

	// keeps the last taken break after the ack
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			break_pc <= '0;
		else if (capture)
			break_pc <= core.pc;
	end

endmodule

/* rtl/trig_csr_apb.sv */
/*
 * apb slave for the trigger csrs
 * csr decode, tcontrol register, tbreakpc readback, read data mux
 */
`timescale 1ns/1ps

module trig_csr_apb #(
	parameter int N_TRIGGERS = 4
) (
	input  logic               clk,
	input  logic               rst_n,
	// apb
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [13:0]        paddr,
	input  trig_pkg::xlen_t    pwdata,
	output trig_pkg::xlen_t    prdata,
	output logic               pready,
	output logic               pslverr,
	// trigger unit side
	output trig_pkg::cfg_req_t cfg,
	input  trig_pkg::xlen_t    cfg_rdata,
	output logic               trig_m_en,
	// break hold side
	input  trig_pkg::xlen_t    break_pc
);
	import trig_pkg::*;

	logic     setup_q;  // set after a setup phase, marks the access phase
	logic     access;
	csr_num_t csr_num;
	logic     is_trig;  // handled by trig_match
	logic     known;
	logic     mte;

	// --------------------------------------------------------------------------
	// apb phase tracking

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			setup_q <= 1'b0;
		else
			setup_q <= psel && !penable;
	end

	assign access  = psel && penable && setup_q;
	assign pready  = access;  // zero wait states
	assign csr_num = paddr[13:2];

	assign is_trig = csr_num == CSR_TSELECT || csr_num == CSR_TDATA1 ||
		csr_num == CSR_TDATA2 || csr_num == CSR_TINFO;
	assign known   = is_trig || csr_num == CSR_TCONTROL || csr_num == CSR_TBREAKPC;
	assign pslverr = access && !known;

	// tinfo is read only, so it never raises wen
	assign cfg = '{
		addr:  csr_num,
		wen:   access && pwrite && is_trig && csr_num != CSR_TINFO,
		wdata: pwdata
	};

	// --------------------------------------------------------------------------
	// tcontrol, only mte is writable

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			mte <= 1'b0;
		else if (access && pwrite && csr_num == CSR_TCONTROL)
			mte <= pwdata[TCONTROL_MTE];
	end

	assign trig_m_en = mte;

	// read data, driven only during a read access phase
	always_comb begin
		prdata = '0;
		if (access && !pwrite) begin
			if (is_trig)
				prdata = cfg_rdata;
			else if (csr_num == CSR_TCONTROL)
				prdata[TCONTROL_MTE] = mte;
			else if (csr_num == CSR_TBREAKPC)
				prdata = break_pc; // last taken break
		end
	end

endmodule

/* rtl/trig_match.sv */
/*
 * breakpoint trigger unit
 * per trigger mcontrol fields and tdata2, tselect indexed csr access,
 * exact pc match producing m-mode or d-mode break requests
 */
`timescale 1ns/1ps

module trig_match #(
	parameter int BREAKPOINT_TRIGGERS = 4
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  trig_pkg::cfg_req_t    cfg,
	output trig_pkg::xlen_t       cfg_rdata,
	input  trig_pkg::core_state_t core,
	input  logic                  trig_m_en,  // tcontrol.mte
	output trig_pkg::break_t      brk
);
	import trig_pkg::*;

	// at least one index bit, also for a single trigger
	localparam int W_IDX = (BREAKPOINT_TRIGGERS > 1) ? $clog2(BREAKPOINT_TRIGGERS) : 1;

	// --------------------------------------------------------------------------
	// configuration state

	xlen_t tselect;  // full value, out of range is legal and selects nothing

	logic  td1_dmode   [BREAKPOINT_TRIGGERS];
	logic  td1_action  [BREAKPOINT_TRIGGERS]; // 0 = m-mode, 1 = d-mode
	logic  td1_m       [BREAKPOINT_TRIGGERS];
	logic  td1_u       [BREAKPOINT_TRIGGERS];
	logic  td1_execute [BREAKPOINT_TRIGGERS];
	xlen_t tdata2      [BREAKPOINT_TRIGGERS]; // match address

	logic [W_IDX-1:0] sel_idx;
	logic             sel_valid;
	logic             sel_writable;

	assign sel_valid = tselect < BREAKPOINT_TRIGGERS;
	assign sel_idx   = tselect[W_IDX-1:0];

	// a d-mode owned trigger is locked outside debug mode
	assign sel_writable = sel_valid && !(td1_dmode[sel_idx] && !core.d_mode);

	// --------------------------------------------------------------------------
	// configuration write port

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tselect <= '0;
			for (int i = 0; i < BREAKPOINT_TRIGGERS; i++) begin
				td1_dmode[i]   <= 1'b0;
				td1_action[i]  <= 1'b0;
				td1_m[i]       <= 1'b0;
				td1_u[i]       <= 1'b0;
				td1_execute[i] <= 1'b0;
				tdata2[i]      <= '0;
			end
		end else if (cfg.wen) begin
			if (cfg.addr == CSR_TSELECT) begin
				tselect <= cfg.wdata;
			end else if (sel_writable) begin
				if (cfg.addr == CSR_TDATA1) begin
					if (core.d_mode)
						td1_dmode[sel_idx] <= cfg.wdata[TD1_DMODE]; // only debugger claims it
					td1_action[sel_idx]  <= cfg.wdata[TD1_ACTION];
					td1_m[sel_idx]       <= cfg.wdata[TD1_M];
					td1_u[sel_idx]       <= cfg.wdata[TD1_U];
					td1_execute[sel_idx] <= cfg.wdata[TD1_EXECUTE];
				end else if (cfg.addr == CSR_TDATA2) begin
					tdata2[sel_idx] <= cfg.wdata;
				end
			end
		end
	end

	// --------------------------------------------------------------------------
	// configuration read port

	always_comb begin
		cfg_rdata = '0;
		case (cfg.addr)
			CSR_TSELECT: cfg_rdata = tselect;
			CSR_TDATA1: begin
				// nonexistent trigger reads as type 0
				if (sel_valid) begin
					cfg_rdata[TD1_TYPE_LSB +: 4] = TRIG_TYPE_MCONTROL;
					cfg_rdata[TD1_DMODE]         = td1_dmode[sel_idx];
					cfg_rdata[TD1_ACTION]        = td1_action[sel_idx];
					cfg_rdata[TD1_M]             = td1_m[sel_idx];
					cfg_rdata[TD1_U]             = td1_u[sel_idx];
					cfg_rdata[TD1_EXECUTE]       = td1_execute[sel_idx];
				end
			end
			CSR_TDATA2: begin
				if (sel_valid)
					cfg_rdata = tdata2[sel_idx];
			end
			CSR_TINFO: cfg_rdata = sel_valid ? TINFO_MCONTROL : TINFO_NONE;
			default:   cfg_rdata = '0;
		endcase
	end

	// --------------------------------------------------------------------------
	// pc match

	logic [BREAKPOINT_TRIGGERS-1:0] hit_d;  // wants a break into d-mode
	logic [BREAKPOINT_TRIGGERS-1:0] hit_m;  // wants a trap into m-mode

	always_comb begin
		hit_d = '0;
		hit_m = '0;
		for (int i = 0; i < BREAKPOINT_TRIGGERS; i++) begin
			// no matching while already halted
			if (td1_execute[i] && tdata2[i] == core.pc && !core.d_mode &&
				(core.m_mode ? td1_m[i] : td1_u[i])) begin
				hit_d[i] = td1_action[i] && td1_dmode[i];
				hit_m[i] = !td1_action[i] && trig_m_en;
			end
		end
	end

	assign brk = '{
		any:    (|hit_d) || (|hit_m),
		d_mode: |hit_d
	};

endmodule

/* rtl/trig_pkg.sv */
/*
 * shared definitions for the debug trigger block
 * word and csr number types, trigger csr numbers,
 * tdata1 field positions and the structs passed between blocks
 */
package trig_pkg;

	// --------------------------------------------------------------------------
	// basic types

	localparam int XLEN      = 32;
	localparam int CSR_NUM_W = 12;

	typedef logic [XLEN-1:0]      xlen_t;    // data word and pc
	typedef logic [CSR_NUM_W-1:0] csr_num_t; // csr number, paddr[13:2]

	// --------------------------------------------------------------------------
	// csr numbers

	localparam csr_num_t CSR_TSELECT  = 12'h7a0;
	localparam csr_num_t CSR_TDATA1   = 12'h7a1;
	localparam csr_num_t CSR_TDATA2   = 12'h7a2;
	localparam csr_num_t CSR_TINFO    = 12'h7a4;
	localparam csr_num_t CSR_TCONTROL = 12'h7a5;
	localparam csr_num_t CSR_TBREAKPC = 12'h7c0; // custom, read only

	// tdata1 (mcontrol) bit positions
	localparam int TD1_TYPE_LSB = 28; // type field is [31:28]
	localparam int TD1_DMODE    = 27;
	localparam int TD1_ACTION   = 12; // only bit 0 of the action field is kept
	localparam int TD1_M        = 6;
	localparam int TD1_U        = 3;
	localparam int TD1_EXECUTE  = 2;

	localparam logic [3:0] TRIG_TYPE_MCONTROL = 4'h2; // address/data match

	// tinfo values, one bit per supported type
	localparam xlen_t TINFO_MCONTROL = 32'h0000_0004; // type 2 only
	localparam xlen_t TINFO_NONE     = 32'h0000_0001; // no trigger at tselect

	localparam int TCONTROL_MTE = 3; // trigger to m-mode enable

	// --------------------------------------------------------------------------
	// structs

	// config access from the csr block into the trigger unit
	typedef struct packed {
		csr_num_t addr;
		logic     wen;
		xlen_t    wdata;
	} cfg_req_t;

	// what the core presents every cycle
	typedef struct packed {
		xlen_t pc;
		logic  pc_valid;
		logic  m_mode;   // 1 = m-mode, 0 = u-mode
		logic  d_mode;
	} core_state_t;

	// combinational match result
	typedef struct packed {
		logic any;
		logic d_mode; // break goes to d-mode
	} break_t;

endpackage

/* rtl/trig_subsys.sv */
/*
 * debug trigger subsystem top level
 * apb csr slave, breakpoint trigger unit, break request holding
 */
`timescale 1ns/1ps

module trig_subsys #(
	parameter int N_TRIGGERS = 4  // 1 to 16
) (
	input  logic            clk,
	input  logic            rst_n,
	// apb slave
	input  logic            psel,
	input  logic            penable,
	input  logic            pwrite,
	input  logic [13:0]     paddr,
	input  trig_pkg::xlen_t pwdata,
	output trig_pkg::xlen_t prdata,
	output logic            pready,
	output logic            pslverr,
	// core
	input  trig_pkg::xlen_t pc,
	input  logic            pc_valid,
	input  logic            m_mode,
	input  logic            d_mode,
	input  logic            break_ack,
	output logic            break_req,
	output logic            break_to_dmode,
	output trig_pkg::xlen_t break_pc
);
	import trig_pkg::*;

	cfg_req_t    cfg;
	xlen_t       cfg_rdata;
	logic        trig_m_en;
	core_state_t core_st;
	break_t      brk;

	assign core_st = '{pc: pc, pc_valid: pc_valid, m_mode: m_mode, d_mode: d_mode};

	trig_csr_apb #(.N_TRIGGERS(N_TRIGGERS)) u_csr_apb (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.cfg       (cfg),
		.cfg_rdata (cfg_rdata),
		.trig_m_en (trig_m_en),
		.break_pc  (break_pc)
	);

	trig_match #(.BREAKPOINT_TRIGGERS(N_TRIGGERS)) u_match (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg       (cfg),
		.cfg_rdata (cfg_rdata),
		.core      (core_st),
		.trig_m_en (trig_m_en),
		.brk       (brk)
	);

	trig_break_hold u_break_hold (
		.clk            (clk),
		.rst_n          (rst_n),
		.core           (core_st),
		.brk            (brk),
		.break_ack      (break_ack),
		.break_req      (break_req),
		.break_to_dmode (break_to_dmode),
		.break_pc       (break_pc)
	);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the trigger subsystem testbench with verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f trig_subsys.f \
	--top-module tb_trig_subsys -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "all tests passed" <<< "$out"; then
	exit 0
fi
echo "simulation did not pass"
exit 1

/* test/tb_trig_subsys.sv */
/*
 * testbench for the debug trigger subsystem
 * reads operations from the vector file, drives apb and the core ports,
 * checks read data, pslverr and break requests, then a random pc sweep
 */
`timescale 1ns/1ps

module tb_trig_subsys;
	import trig_pkg::*;

	localparam int WAIT_MAX = 8;   // cycles before any wait gives up
	localparam int N_RAND   = 20;  // pcs in the random sweep

	logic        clk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [13:0] paddr;
	xlen_t       pwdata;
	xlen_t       prdata;
	logic        pready;
	logic        pslverr;
	xlen_t       pc;
	logic        pc_valid;
	logic        m_mode;
	logic        d_mode;
	logic        break_ack;
	logic        break_req;
	logic        break_to_dmode;
	xlen_t       break_pc;

	int    errors;
	int    timeouts;
	int    checks;
	int    seed;
	xlen_t tdata2_seen [$];  // every value written to tdata2
	logic  held;             // a break is expected to be pending
	xlen_t held_pc;          // pc of the first break since the last ack

	trig_subsys #(.N_TRIGGERS(4)) UUT (
		.clk            (clk),
		.rst_n          (rst_n),
		.psel           (psel),
		.penable        (penable),
		.pwrite         (pwrite),
		.paddr          (paddr),
		.pwdata         (pwdata),
		.prdata         (prdata),
		.pready         (pready),
		.pslverr        (pslverr),
		.pc             (pc),
		.pc_valid       (pc_valid),
		.m_mode         (m_mode),
		.d_mode         (d_mode),
		.break_ack      (break_ack),
		.break_req      (break_req),
		.break_to_dmode (break_to_dmode),
		.break_pc       (break_pc)
	);

	always #20 clk = ~clk;  // 40 ns period

	// ------------------------------------------------------------------------
	// expected value helpers

	// only the six trigger csrs are decoded
	function automatic logic csr_is_unknown(input csr_num_t csr);
		case (csr)
			CSR_TSELECT, CSR_TDATA1, CSR_TDATA2, CSR_TINFO, CSR_TCONTROL, CSR_TBREAKPC:
				return 1'b0;
			default:
				return 1'b1;
		endcase
	endfunction

	function automatic logic is_programmed(input xlen_t addr);
		logic found;
		found = 1'b0;
		foreach (tdata2_seen[i])
			if (tdata2_seen[i] == addr)
				found = 1'b1;
		return found;
	endfunction

	// ------------------------------------------------------------------------
	// bus and core drivers

	// one apb transfer, setup then access, dm is the core d_mode during it
	task automatic apb_access(input logic wr, input csr_num_t csr, input xlen_t wdata,
			input logic dm, input xlen_t exp_rdata);
		int n;
		n = 0;
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= {csr, 2'b00};  // csr number sits at paddr[13:2]
		pwdata  <= wdata;
		d_mode  <= dm;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (!pready && n < WAIT_MAX) begin
			@(negedge clk);
			n++;
		end
		if (!pready) begin
			$display("timeout: pready never came for csr %h", csr);
			timeouts++;
		end else begin
			checks++;
			if (pslverr !== csr_is_unknown(csr)) begin
				$display("FAILED %0t: pslverr %b for csr %h", $time, pslverr, csr);
				errors++;
			end
			if (!wr && prdata !== exp_rdata) begin
				$display("FAILED %0t: csr %h read %h, expected %h", $time, csr, prdata,
					exp_rdata);
				errors++;
			end
		end
		@(posedge clk);  // write lands at this edge
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	// pc valid for one cycle, then the break outcome
	task automatic present_pc(input xlen_t addr, input logic m, input logic dm,
			input logic exp_req, input logic exp_tod);
		int n;
		n = 0;
		@(posedge clk);
		pc       <= addr;
		m_mode   <= m;
		d_mode   <= dm;
		pc_valid <= 1'b1;
		@(posedge clk);
		pc_valid <= 1'b0;
		@(negedge clk);
		if (exp_req) begin
			// a pending request keeps its first pc
			if (!held) begin
				held_pc = addr;
				held    = 1'b1;
			end
			while (!break_req && n < WAIT_MAX) begin
				@(negedge clk);
				n++;
			end
			if (!break_req) begin
				$display("timeout: no break request for pc %h", addr);
				timeouts++;
			end else begin
				checks++;
				if (n != 0) begin
					$display("FAILED %0t: break for pc %h came %0d cycles late", $time, addr, n);
					errors++;
				end
				if (break_to_dmode !== exp_tod) begin
					$display("FAILED %0t: break_to_dmode %b for pc %h", $time,
						break_to_dmode, addr);
					errors++;
				end
				if (break_pc !== held_pc) begin
					$display("FAILED %0t: break_pc %h, expected %h", $time, break_pc,
						held_pc);
					errors++;
				end
			end
		end else begin
			checks++;
			if (break_req !== 1'b0 || break_to_dmode !== 1'b0) begin
				$display("FAILED %0t: unexpected break for pc %h", $time, addr);
				errors++;
			end
		end
	endtask

	task automatic acknowledge_break;
		int n;
		n = 0;
		@(posedge clk);
		break_ack <= 1'b1;
		@(posedge clk);
		break_ack <= 1'b0;
		held = 1'b0;
		@(negedge clk);
		while (break_req && n < WAIT_MAX) begin
			@(negedge clk);
			n++;
		end
		if (break_req) begin
			$display("timeout: break request stays high after the acknowledge");
			timeouts++;
		end else begin
			checks++;
			if (n != 0) begin
				$display("FAILED %0t: break_req fell %0d cycles late", $time, n);
				errors++;
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// vector file and random sweep

	task automatic run_vectors;
		int               fd;
		int               code;
		logic [7:0]       op;    // single character operation
		logic [8*128-1:0] line;  // rest of a comment line
		csr_num_t         csr;
		xlen_t            data;
		xlen_t            addr;
		logic             f0;
		logic             f1;
		logic             f2;
		logic             f3;
		fd = $fopen("test/trig_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file test/trig_vectors.txt");
			errors++;
			return;
		end
		code = $fscanf(fd, "%s", op);
		while (code == 1) begin
			case (op)
				"#": code = $fgets(line, fd);
				"W": begin
					code = $fscanf(fd, "%h %h %h", csr, data, f0);
					if (csr == CSR_TDATA2)
						tdata2_seen.push_back(data);
					apb_access(1'b1, csr, data, f0, '0);
				end
				"R": begin
					code = $fscanf(fd, "%h %h", csr, data);
					apb_access(1'b0, csr, '0, d_mode, data);  // keeps the core mode
				end
				"P": begin
					code = $fscanf(fd, "%h %h %h %h %h", addr, f0, f1, f2, f3);
					present_pc(addr, f0, f1, f2, f3);
				end
				"A": acknowledge_break();
				default: begin
					$display("unknown operation %s in the vector file", op);
					errors++;
				end
			endcase
			code = $fscanf(fd, "%s", op);
		end
		$fclose(fd);
	endtask

	// random pcs, moved off every programmed address
	task automatic random_pc_sweep;
		xlen_t addr;
		xlen_t rnd;
		for (int i = 0; i < N_RAND; i++) begin
			addr = $random(seed);
			while (is_programmed(addr))
				addr = addr + 32'h4;
			rnd = $random(seed);
			present_pc(addr, rnd[0], 1'b0, 1'b0, 1'b0);
		end
	endtask

	// ------------------------------------------------------------------------
	// main sequence

	initial begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		pc        = '0;
		pc_valid  = 1'b0;
		m_mode    = 1'b1;
		d_mode    = 1'b0;
		break_ack = 1'b0;
		errors    = 0;
		timeouts  = 0;
		checks    = 0;
		seed      = 49;
		held      = 1'b0;
		held_pc   = '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		checks++;
		if (break_req !== 1'b0 || break_to_dmode !== 1'b0 || pslverr !== 1'b0 ||
			prdata !== '0) begin
			$display("FAILED %0t: outputs not cleared by reset", $time);
			errors++;
		end
		run_vectors();
		random_pc_sweep();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0 && checks > 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* test/trig_vectors.txt */
# W csr data dmode | R csr expected | P pc m_mode d_mode req to_dmode | A ack
# all fields hex, lines starting with # are skipped
# reset values and unknown csrs
R 7a0 00000000
R 7a1 20000000
R 7a2 00000000
R 7a4 00000004
R 7a5 00000000
R 7c0 00000000
R 7a3 00000000
R 300 00000000
# trigger 0 m-mode action, junk bits and dmode from outside d-mode dropped
W 7a1 08000fc4 0
R 7a1 20000044
W 7a2 80001000 0
# tselect past the last trigger
W 7a0 00000005 0
R 7a0 00000005
R 7a1 00000000
R 7a2 00000000
R 7a4 00000001
W 7a2 deadbeef 0
W 7a0 00000001 0
R 7a2 00000000
# trigger 1 owned by d-mode
W 7a1 0800104c 1
W 7a2 80002000 1
R 7a1 2800104c
W 7a1 00000000 0
W 7a2 11111111 0
R 7a1 2800104c
R 7a2 80002000
# trigger 2 u-mode only, trigger 3 execute clear
W 7a0 00000002 0
W 7a1 0000000c 0
W 7a2 80003000 0
W 7a0 00000003 0
W 7a1 00000040 0
W 7a2 80004000 0
# matches
P 80002000 1 0 1 1
A
P 80002000 0 0 1 1
A
P 80002000 1 1 0 0
P 80001000 1 0 0 0
W 7a5 00000008 0
R 7a5 00000008
P 80001000 1 0 1 0
A
P 80003000 1 0 0 0
P 80003000 0 0 1 0
A
P 80004000 1 0 0 0
# back pressure keeps the first pc
P 80001000 1 0 1 0
P 80002000 1 0 1 0
R 7c0 80001000
A
R 7c0 80001000

/* trig_subsys.f */
rtl/trig_pkg.sv
rtl/trig_csr_apb.sv
rtl/trig_match.sv
rtl/trig_break_hold.sv
rtl/trig_subsys.sv
test/tb_trig_subsys.sv
